//--- bench/dualBusCore_vectors.txt
// mainOp mainAddr mainData subOp subAddr subData expMainRead expSubRead, all hex
// Op 0 idles, 1 reads, 2 writes; FFFF in the first column ends the list.
2 0123 C3 1 1234 00 00 FF
1 0123 00 0 0000 00 C3 00
2 8000 12 0 0000 00 00 00
1 8000 00 1 F000 00 FF FF
2 FC81 A5 2 D382 3C 00 00
1 FC82 00 1 D381 00 3C A5
2 FC90 11 2 D390 22 00 00
1 FC90 00 1 D390 00 22 22
2 FD05 80 0 0000 00 00 00
2 0200 99 0 0000 00 00 00
1 FD05 00 1 D385 00 7F 5A
2 FC85 5A 0 0000 00 00 00
1 0200 00 0 0000 00 99 00
2 FD05 00 0 0000 00 00 00
0 0000 00 0 0000 00 00 00
1 FD05 00 0 0000 00 FE 00
FFFF 0000 00 0 0000 00 00 00

//--- dualBusCore.f
design/fm7SharedPkg.sv
design/mainDecode.sv
design/haltCtrl.sv
design/sharedRamArbiter.sv
design/sharedRam.sv
design/mainRam.sv
design/dualBusCore.sv
bench/dualBusCore_props.sv
bench/dualBusCoreTb.sv

//--- Bender.yml
package:
  name: dual_bus_core

sources:
  - design/fm7SharedPkg.sv
  - design/mainDecode.sv
  - design/haltCtrl.sv
  - design/sharedRamArbiter.sv
  - design/sharedRam.sv
  - design/mainRam.sv
  - design/dualBusCore.sv
  - target: test
    files:
      - bench/dualBusCore_props.sv
      - bench/dualBusCoreTb.sv

//--- bench/dualBusCoreTb.sv
// ################################################
// Testbench for the dual bus core.
// Runs the vector file on both buses and checks read data.
// ################################################

`timescale 1ns/100ps

module dualBusCoreTb
  import fm7SharedPkg::*;
();

  logic        CLKSYS = 1'b0;
  logic        rstN;
  busReq_t     mainReq;
  busReq_t     subReq;
  busRsp_t     mainRsp;
  busRsp_t     subRsp;
  logic        subHalted;
  logic [15:0] vecMem [512];
  int          numVec;
  int          mismatches;
  int          otherErrors;
  logic        mainBusy;
  logic        subBusy;
  logic [7:0]  expSub;
  int          subVec;

  dualBusCore DUT (.*);

  always #2 CLKSYS = ~CLKSYS;

  // Op 1 is a read, op 2 a write, anything else leaves the port idle.
  function automatic busReq_t makeReq(input logic [15:0] op, addr, data);
    busReq_t req;
    req.addr   = addr;
    req.wrData = data[7:0];
    req.rd     = (op == 16'h1);
    req.wr     = (op == 16'h2);
    return req;
  endfunction

  task automatic checkByte(input string name, input int v, input logic [7:0] got, exp);
    if (got !== exp) begin
      $display("MISMATCH %s in vector %0d: got %h, expected %h", name, v, got, exp);
      mismatches++;
    end
  endtask

  // A halted sub request stays on the bus across vectors until it is served.
  task automatic runVector(input int v);
    logic mainAcc;
    logic subAcc;
    logic haltSeen;
    int   waitCnt;
    waitCnt  = 0;
    mainReq  = makeReq(vecMem[v*8], vecMem[v*8+1], vecMem[v*8+2]);
    mainBusy = mainReq.rd | mainReq.wr;
    if (!subBusy) begin
      subReq  = makeReq(vecMem[v*8+3], vecMem[v*8+4], vecMem[v*8+5]);
      subBusy = subReq.rd | subReq.wr;
      expSub  = vecMem[v*8+7][7:0];
      subVec  = v;
    end
    do begin
      // The ready levels settle in the low phase and are sampled before the edge.
      #1;
      mainAcc  = mainBusy & mainRsp.rdy;
      subAcc   = subBusy & subRsp.rdy;
      haltSeen = subHalted;
      @(negedge CLKSYS);
      if (mainAcc) begin
        if (mainReq.rd)
          checkByte("mainRsp.rdData", v, mainRsp.rdData, vecMem[v*8+6][7:0]);
        // The busy bit of the halt register is the inverse of subHalted at the edge.
        if (mainReq.rd && mainReq.addr == HALT_REG_ADDR)
          checkByte("subHalted", v, {7'h00, haltSeen}, {7'h00, ~vecMem[v*8+6][7]});
        mainReq  = '0;
        mainBusy = 1'b0;
      end
      if (subAcc) begin
        if (subReq.rd)
          checkByte("subRsp.rdData", subVec, subRsp.rdData, expSub);
        subReq  = '0;
        subBusy = 1'b0;
      end else if (subBusy && !haltSeen) begin
        waitCnt++;
        if (waitCnt > 2) begin
          $display("Sub request of vector %0d was not served while the sub side ran", subVec);
          otherErrors++;
          subReq  = '0;
          subBusy = 1'b0;
        end
      end
    end while (mainBusy || (subBusy && !subHalted));
  endtask

  initial begin
    mainReq     = '0;
    subReq      = '0;
    rstN        = 1'b0;
    mismatches  = 0;
    otherErrors = 0;
    mainBusy    = 1'b0;
    subBusy     = 1'b0;
    numVec      = 0;
    void'($urandom(32'h5012_e252));
    $readmemh("bench/dualBusCore_vectors.txt", vecMem);
    while (numVec < $size(vecMem) / 8 && vecMem[numVec * 8] != 16'hFFFF)
      numVec++;
    if (numVec == 0) begin
      $display("No vectors were read from the vector file");
      otherErrors++;
    end
    repeat (16) @(negedge CLKSYS);
    rstN = 1'b1;
    for (int v = 0; v < numVec; v++) begin
      if (!subBusy)
        repeat ($urandom_range(3)) @(negedge CLKSYS);
      runVector(v);
    end
    if (subBusy) begin
      $display("Sub request of vector %0d was still pending after the last vector", subVec);
      otherErrors++;
    end
    $display("Run complete: %0d mismatches, %0d other errors", mismatches, otherErrors);
    if (mismatches + otherErrors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // Each vector gets 20 cycles, counted from the end of reset.
  initial begin
    @(posedge rstN);
    repeat (numVec * 20 + 4) @(posedge CLKSYS);
    $display("Timeout: the vectors did not complete in the allowed time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- bench/dualBusCore_props.sv
// ################################################
// Arbiter and sub halt protocol assertions.
// ################################################

`timescale 1ns/100ps

module dualBusCore_props
  import fm7SharedPkg::*;
(
  input logic      CLKSYS,
  input logic      rstN,
  input logic      mainStb,
  input logic      subStb,
  input logic      mainRdy,
  input logic      subRdy,
  input logic      subHalted,
  input arbOwner_t lastOwner
);

  assert property (@(posedge CLKSYS) disable iff (!rstN) !(mainRdy && subRdy))
    else $error("Both ports were granted the shared RAM in one cycle");

  // Every tie hands the RAM to the port that did not win last.
  assert property (@(posedge CLKSYS) disable iff (!rstN)
    (mainStb && subStb && !subHalted) |=> (lastOwner != $past(lastOwner)))
    else $error("Tie did not hand the RAM to the other port");

  assert property (@(posedge CLKSYS) disable iff (!rstN)
    (mainStb && !mainRdy) |=> (mainRdy || !mainStb))
    else $error("Main request waited more than one cycle");

  assert property (@(posedge CLKSYS) disable iff (!rstN)
    (subStb && !subHalted && !subRdy) |=> (subRdy || !subStb || subHalted))
    else $error("Sub request waited more than one cycle");

  assert property (@(posedge CLKSYS) disable iff (!rstN) subHalted |-> !subRdy)
    else $error("Sub side was granted while halted");

endmodule

bind sharedRamArbiter dualBusCore_props uProps (.*);

//--- design/dualBusCore.sv
// ################################################
// Dual bus core top level.
// Connects the main and sub buses to the shared RAM.
// ################################################

`timescale 1ns/100ps

module dualBusCore
  import fm7SharedPkg::*;
(
  input  logic    CLKSYS,
  input  logic    rstN,
  input  busReq_t mainReq,
  input  busReq_t subReq,
  output busRsp_t mainRsp,
  output busRsp_t subRsp,
  output logic    subHalted
);

  mainRegion_t mainRegion;
  mainRegion_t mainRegionQ;
  logic [11:0] mainOffset;
  logic        mainStrobe;
  logic        subStrobe;
  logic        subInWindow;
  logic        subIdleQ;
  logic        mainRdy;
  logic        subRdy;
  logic        arbMainRdy;
  logic        arbSubRdy;
  logic [7:0]  arbMainRdData;
  logic [7:0]  arbSubRdData;
  logic [7:0]  mainRamRdData;
  logic [7:0]  haltRdData;
  logic [7:0]  ramRdData;
  logic [7:0]  ramWrData;
  logic [6:0]  ramAddr;
  logic        ramWe;

  assign mainStrobe  = mainReq.rd | mainReq.wr;
  assign subStrobe   = subReq.rd | subReq.wr;
  assign subInWindow = (subReq.addr[15:7] == SHARED_BASE_SUB[15:7]);

  mainDecode uMainDecode (
    .req    (mainReq),
    .region (mainRegion),
    .offset (mainOffset)
  );

  mainRam uMainRam (
    .CLKSYS (CLKSYS),
    .en     (mainStrobe & (mainRegion == regMainRam)),
    .we     (mainReq.wr),
    .addr   (mainOffset),
    .wrData (mainReq.wrData),
    .rdData (mainRamRdData)
  );

  haltCtrl uHaltCtrl (
    .CLKSYS    (CLKSYS),
    .rstN      (rstN),
    .wrStb     (mainReq.wr & (mainRegion == regHalt)),
    .rdStb     (mainReq.rd & (mainRegion == regHalt)),
    .wrData    (mainReq.wrData),
    .subActive (subStrobe),
    .rdData    (haltRdData),
    .subHalted (subHalted)
  );

  sharedRamArbiter uArbiter (
    .CLKSYS     (CLKSYS),
    .rstN       (rstN),
    .mainStb    (mainStrobe & (mainRegion == regShared)),
    .subStb     (subStrobe & subInWindow),
    .mainOffset (mainOffset[6:0]),
    .subOffset  (subReq.addr[6:0]),
    .mainReq    (mainReq),
    .subReq     (subReq),
    .subHalted  (subHalted),
    .ramRdData  (ramRdData),
    .mainRdy    (arbMainRdy),
    .subRdy     (arbSubRdy),
    .mainRdData (arbMainRdData),
    .subRdData  (arbSubRdData),
    .ramAddr    (ramAddr),
    .ramWe      (ramWe),
    .ramWrData  (ramWrData),
    .lastOwner  ()
  );

  sharedRam uSharedRam (
    .CLKSYS (CLKSYS),
    .addr   (ramAddr),
    .we     (ramWe),
    .wrData (ramWrData),
    .rdData (ramRdData)
  );

  // Only the shared window can stall, everything else answers at once.
  assign mainRdy = (mainRegion == regShared) ? arbMainRdy : mainStrobe;
  assign subRdy  = subInWindow ? arbSubRdy : (subStrobe & ~subHalted);

  // Remember where the last accepted read went, for the data mux.
  always_ff @(posedge CLKSYS or negedge rstN) begin
    if (!rstN) begin
      mainRegionQ <= regNone;
      subIdleQ    <= 1'b1;
    end else begin
      if (mainRdy && mainReq.rd) begin
        mainRegionQ <= mainRegion;
      end
      if (subRdy && subReq.rd) begin
        subIdleQ <= ~subInWindow;
      end
    end
  end

  always_comb begin
    case (mainRegionQ)
      regMainRam: mainRsp.rdData = mainRamRdData;
      regShared:  mainRsp.rdData = arbMainRdData;
      regHalt:    mainRsp.rdData = haltRdData;
      default:    mainRsp.rdData = IDLE_DATA;
    endcase
  end

  assign mainRsp.rdy   = mainRdy;
  assign subRsp.rdy    = subRdy;
  assign subRsp.rdData = subIdleQ ? IDLE_DATA : arbSubRdData;

endmodule

//--- design/mainRam.sv
// ################################################
// 4 KiB private main RAM with a registered read.
// ################################################

`timescale 1ns/100ps

module mainRam
  import fm7SharedPkg::*;
(
  input  logic        CLKSYS,
  input  logic        en,
  input  logic        we,
  input  logic [11:0] addr,
  input  logic [7:0]  wrData,
  output logic [7:0]  rdData
);

  logic [7:0] mem [MAIN_RAM_DEPTH];

  // A write leaves the read register alone.
  always_ff @(posedge CLKSYS) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wrData;
      end else begin
        rdData <= mem[addr];
      end
    end
  end

endmodule

//--- design/sharedRam.sv
// ################################################
// 128-byte shared RAM with a registered read.
// ################################################

`timescale 1ns/100ps

module sharedRam
  import fm7SharedPkg::*;
(
  input  logic       CLKSYS,
  input  logic [6:0] addr,
  input  logic       we,
  input  logic [7:0] wrData,
  output logic [7:0] rdData
);

  logic [7:0] mem [SHARED_DEPTH];

  always_ff @(posedge CLKSYS) begin
    if (we) begin
      mem[addr] <= wrData;
    end
    rdData <= mem[addr];
  end

endmodule

//--- design/sharedRamArbiter.sv
// ################################################
// Round-robin arbiter for the shared RAM.
// Grants one bus per cycle and returns read data.
// ################################################

`timescale 1ns/100ps

module sharedRamArbiter
  import fm7SharedPkg::*;
(
  input  logic       CLKSYS,
  input  logic       rstN,
  input  logic       mainStb,
  input  logic       subStb,
  input  logic [6:0] mainOffset,
  input  logic [6:0] subOffset,
  input  busReq_t    mainReq,
  input  busReq_t    subReq,
  input  logic       subHalted,
  input  logic [7:0] ramRdData,
  output logic       mainRdy,
  output logic       subRdy,
  output logic [7:0] mainRdData,
  output logic [7:0] subRdData,
  output logic [6:0] ramAddr,
  output logic       ramWe,
  output logic [7:0] ramWrData,
  output arbOwner_t  lastOwner
);

  logic       subEff;
  logic       grantMain;
  logic       grantSub;
  logic       mainInFlight;
  logic       subInFlight;
  logic [7:0] mainHold;
  logic [7:0] subHold;

  // A halted sub side is not a contender.
  assign subEff = subStb & ~subHalted;

  assign grantMain = mainStb & (~subEff | (lastOwner == ownSub));
  assign grantSub  = subEff & (~mainStb | (lastOwner == ownMain));

  assign mainRdy = grantMain;
  assign subRdy  = grantSub;

  assign ramAddr   = grantSub ? subOffset : mainOffset;
  assign ramWrData = grantSub ? subReq.wrData : mainReq.wrData;
  assign ramWe     = (grantMain & mainReq.wr) | (grantSub & subReq.wr);

  always_ff @(posedge CLKSYS or negedge rstN) begin
    if (!rstN) begin
      lastOwner    <= ownSub;
      mainInFlight <= 1'b0;
      subInFlight  <= 1'b0;
    end else begin
      if (grantMain) begin
        lastOwner <= ownMain;
      end else if (grantSub) begin
        lastOwner <= ownSub;
      end
      mainInFlight <= grantMain & mainReq.rd;
      subInFlight  <= grantSub & subReq.rd;
    end
  end

  // The RAM output goes straight through in the cycle after the grant,
  // and the hold registers keep it until the next read on that port.
  always_ff @(posedge CLKSYS) begin
    if (mainInFlight) begin
      mainHold <= ramRdData;
    end
    if (subInFlight) begin
      subHold <= ramRdData;
    end
  end

  assign mainRdData = mainInFlight ? ramRdData : mainHold;
  assign subRdData  = subInFlight ? ramRdData : subHold;

endmodule

//--- design/haltCtrl.sv
// ################################################
// Sub CPU halt control with the busy readback.
// ################################################

`timescale 1ns/100ps

module haltCtrl (
  input  logic       CLKSYS,
  input  logic       rstN,
  input  logic       wrStb,
  input  logic       rdStb,
  input  logic [7:0] wrData,
  input  logic       subActive,
  output logic [7:0] rdData,
  output logic       subHalted
);

  logic haltReq;

  always_ff @(posedge CLKSYS or negedge rstN) begin
    if (!rstN) begin
      haltReq <= 1'b0;
    end else if (wrStb) begin
      haltReq <= wrData[7];
    end
  end

  // The sub side only enters halt between its accesses, but leaves it at once.
  always_ff @(posedge CLKSYS or negedge rstN) begin
    if (!rstN) begin
      subHalted <= 1'b0;
    end else if (!haltReq) begin
      subHalted <= 1'b0;
    end else if (!subActive) begin
      subHalted <= 1'b1;
    end
  end

  // Bit 7 is busy (active low halted), bit 0 the request.
  always_ff @(posedge CLKSYS) begin
    if (rdStb) begin
      rdData <= {~subHalted, 6'b111111, haltReq};
    end
  end

endmodule

//--- design/mainDecode.sv
// ################################################
// Main bus address decoder.
// Maps an address to its target region and offset.
// ################################################

`timescale 1ns/100ps

module mainDecode
  import fm7SharedPkg::*;
(
  input  busReq_t     req,
  output mainRegion_t region,
  output logic [11:0] offset
);

  logic inMainRam;
  logic inShared;
  logic inHalt;

  assign inMainRam = (req.addr < MAIN_RAM_DEPTH);
  assign inShared  = (req.addr[15:7] == SHARED_BASE_MAIN[15:7]);
  assign inHalt    = (req.addr == HALT_REG_ADDR);

  always_comb begin
    region = regNone;
    offset = 12'h000;
    if (inMainRam) begin
      region = regMainRam;
      offset = req.addr[11:0];
    end else if (inShared) begin
      region = regShared;
      offset = {5'b00000, req.addr[6:0]};
    end else if (inHalt) begin
      // A single register, so the offset stays zero.
      region = regHalt;
    end
  end

endmodule

//--- design/fm7SharedPkg.sv
// ################################################
// FM-7 shared memory subsystem definitions.
// Address map, bus request and response types, memory sizes.
// ################################################

package fm7SharedPkg;

  // Shared window as seen from each bus.
  localparam logic [15:0] SHARED_BASE_MAIN = 16'hFC80;
  localparam logic [15:0] SHARED_BASE_SUB  = 16'hD380;
  localparam int          SHARED_DEPTH     = 128;

  // Halt/busy register on the main bus.
  localparam logic [15:0] HALT_REG_ADDR = 16'hFD05;

  // Private main RAM sits at 0x0000 to 0x0FFF.
  localparam int MAIN_RAM_DEPTH = 4096;

  localparam logic [7:0] IDLE_DATA = 8'hFF;

  typedef enum logic [1:0] {
    regMainRam,
    regShared,
    regHalt,
    regNone
  } mainRegion_t;

  typedef enum logic {
    ownMain,
    ownSub
  } arbOwner_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wrData;
    logic        rd;
    logic        wr;
  } busReq_t;

  typedef struct packed {
    logic [7:0] rdData;
    logic       rdy;
  } busRsp_t;

endpackage
